// File: build.f
verilog/usb_dfu_pkg.sv
verilog/setup_capture.sv
verilog/ctrl_xfr_fsm.sv
verilog/request_decoder.sv
verilog/in_data_source.sv
verilog/usb_dfu_ctrl_ep.sv
dv/ep_clock_gen.sv
dv/ctrl_ep_assert.sv
dv/tb_usb_dfu_ctrl_ep.sv

// File: run_sim.sh
#!/bin/sh
# compile and run the control endpoint testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_usb_dfu_ctrl_ep -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^SIMULATION PASSED$" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1

// File: dv/tb_usb_dfu_ctrl_ep.sv
`default_nettype none

module tb_usb_dfu_ctrl_ep;
  import usb_dfu_pkg::*;

  localparam int num_rows    = 15;
  localparam int row_bound   = 200;  // cycles one transfer may need
  localparam int cycle_limit = num_rows * row_bound + 500;

  typedef struct packed {
    logic [63:0] setup;     // byte 0 in bits 7:0
    logic [7:0]  count;     // in bytes expected
    logic [47:0] head;      // leading bytes, byte 0 low
    logic [2:0]  head_len;
    logic        ramp;      // byte i is head byte 0 plus i
    logic        stall;
    logic        gaps;      // random data_free gaps
  } req_row_t;

  logic        clk;
  logic        reset;
  out_ep_in_t  out_ep;
  logic        out_ep_req;
  in_ep_in_t   in_ep;
  in_ep_out_t  in_ep_o;
  logic [6:0]  dev_addr;

  req_row_t    rows [num_rows];
  int          fill_idx;
  logic [7:0]  got [$];
  logic [31:0] rng;
  logic [6:0]  model_addr;  // address the device should answer on
  int          errors;
  int          checks;
  int          cycles = 0;

  ep_clock_gen #(.period(20)) u_clock (.clk(clk));

  usb_dfu_ctrl_ep #(
    .max_in_packet_size  (32),
    .max_out_packet_size (32),
    .fw_page_size        (4096)
  ) uut (
    .clk        (clk),
    .reset      (reset),
    .out_ep     (out_ep),
    .out_ep_req (out_ep_req),
    .in_ep      (in_ep),
    .in_ep_o    (in_ep_o),
    .dev_addr   (dev_addr)
  );

  //////////////////////////////
  // helpers
  function automatic logic [63:0] make_setup(input logic [7:0] bm, input logic [7:0] req,
                                             input logic [15:0] value, input logic [15:0] len);
    return {len, 16'h0000, value, req, bm};  // w_index always 0
  endfunction

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [7:0] expected_byte(input req_row_t r, input int i);
    if (r.ramp) begin
      return r.head[7:0] + 8'(i);  // page byte equals its address
    end
    return r.head[i * 8 +: 8];
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    assert (actual == expected) else begin
      errors++;
      $display("[ERROR] t=%0t %s got 0x%0h expected 0x%0h", $time, name, actual, expected);
    end
  endtask

  task automatic add_row(input logic [63:0] setup, input logic [7:0] count,
                         input logic [47:0] head, input logic [2:0] head_len,
                         input logic ramp, input logic stall, input logic gaps);
    rows[fill_idx] = {setup, count, head, head_len, ramp, stall, gaps};
    fill_idx++;
  endtask

  //////////////////////////////
  // request table
  task automatic load_table();
    fill_idx = 0;
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0100, 16'd64), 8'd18, 48'h0112, 3'd2,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0600, 16'd10), 8'd0, 48'h0, 3'd0,
            1'b0, 1'b1, 1'b0);  // qualifier
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0100, 16'd8), 8'd8, 48'h0112, 3'd2,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0200, 16'd255), 8'd27, 48'h0209, 3'd2,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0300, 16'd255), 8'd4, 48'h0409_0304,
            3'd4, 1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h00, req_set_address, 16'h002a, 16'd0), 8'd0, 48'h0, 3'd0,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h00, req_set_configuration, 16'h0001, 16'd0), 8'd0, 48'h0, 3'd0,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_getstate, 16'h0000, 16'd1), 8'd1, 48'h02, 3'd1,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_getstatus, 16'h0000, 16'd6), 8'd6, 48'h0002_0000_0000,
            3'd6, 1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_upload, 16'd5, 16'd32), 8'd32, 48'h00, 3'd1,
            1'b1, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_upload, 16'd6, 16'd32), 8'd32, 48'h20, 3'd1,
            1'b1, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_getstate, 16'h0000, 16'd1), 8'd1, 48'h09, 3'd1,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h21, dfu_abort, 16'h0000, 16'd0), 8'd0, 48'h0, 3'd0,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'ha1, dfu_getstate, 16'h0000, 16'd1), 8'd1, 48'h02, 3'd1,
            1'b0, 1'b0, 1'b0);
    add_row(make_setup(8'h80, req_get_descriptor, 16'h0200, 16'd255), 8'd27, 48'h0209, 3'd2,
            1'b0, 1'b0, 1'b1);  // back-pressure
  endtask

  //////////////////////////////
  // host model
  task automatic send_setup(input logic [63:0] s);
    for (int i = 0; i <= 8; i++) begin
      @(posedge clk);
      out_ep.data_avail <= (i < 8);
      out_ep.grant      <= (i < 8);
      out_ep.setup      <= (i < 8);
      if (i > 0) begin
        out_ep.data <= s[(i - 1) * 8 +: 8];  // byte lags its grant cycle
      end
      @(negedge clk);
      check_value("out_ep_req", 32'(out_ep_req), 32'(i < 8));  // follows data_avail
    end
  endtask

  task automatic pulse_in_acked();
    @(posedge clk);
    in_ep.grant     <= 1'b0;
    in_ep.data_free <= 1'b0;
    in_ep.acked     <= 1'b1;
    @(negedge clk);
    check_value("dev_addr", 32'(dev_addr), 32'(model_addr));  // old address until the edge
    @(posedge clk);
    in_ep.acked <= 1'b0;
  endtask

  task automatic pulse_out_acked();
    @(posedge clk);
    out_ep.acked <= 1'b1;
    @(posedge clk);
    out_ep.acked <= 1'b0;
  endtask

  task automatic run_row(input int n);
    req_row_t r;
    logic     has_data;
    logic     done;
    logic     stalled;
    r        = rows[n];
    has_data = (r.setup[63:48] != 16'h0000);
    done     = 1'b0;
    stalled  = 1'b0;
    got.delete();
    send_setup(r.setup);
    while (!done && !stalled) begin
      @(posedge clk);
      in_ep.grant <= 1'b1;
      if (r.gaps) begin
        rng = xorshift(rng);
        in_ep.data_free <= rng[0] | rng[1];  // about one gap in four
      end else begin
        in_ep.data_free <= 1'b1;
      end
      @(negedge clk);
      if (in_ep_o.data_put && in_ep.grant) begin
        got.push_back(in_ep_o.data);
      end
      done    = in_ep_o.data_done;
      stalled = in_ep_o.stall;
    end

    if (stalled) begin
      @(posedge clk);
      in_ep.grant     <= 1'b0;
      in_ep.data_free <= 1'b0;
    end else begin
      pulse_in_acked();
      if (has_data) begin
        pulse_out_acked();  // status out
      end
    end

    // address moves only after the status stage
    if (r.setup[15:0] == {req_set_address, 8'h00}) begin
      model_addr = r.setup[22:16];
    end
    @(negedge clk);
    check_value("dev_addr", 32'(dev_addr), 32'(model_addr));

    check_value($sformatf("row %0d in_ep_o.stall", n), 32'(stalled), 32'(r.stall));
    check_value($sformatf("row %0d byte count", n), got.size(), 32'(r.count));
    for (int i = 0; i < got.size(); i++) begin
      if (r.ramp || i < int'(r.head_len)) begin
        check_value($sformatf("row %0d in_ep_o.data byte %0d", n, i), 32'(got[i]),
                    32'(expected_byte(r, i)));
      end
    end
  endtask

  //////////////////////////////
  // main sequence
  initial begin
    reset      = 1'b1;
    out_ep     = '0;
    in_ep      = '0;
    rng        = 32'hcba5_e309;
    model_addr = '0;
    errors     = 0;
    checks     = 0;
    load_table();
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    for (int n = 0; n < num_rows; n++) begin
      run_row(n);
      repeat (2) @(posedge clk);  // idle gap between transfers
    end
    $display("checks run %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, a transfer never finished", cycles);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: dv/ctrl_ep_assert.sv
`default_nettype none

module ctrl_ep_assert (
  input logic                    clk,
  input logic                    reset,
  input usb_dfu_pkg::in_ep_in_t  in_ep,
  input usb_dfu_pkg::in_ep_out_t in_ep_o
);

  // a byte not taken stays offered
  held_byte_waits: assert property (@(posedge clk) disable iff (reset)
    (in_ep_o.req && !(in_ep_o.data_put && in_ep.grant))
      |=> (in_ep_o.req && $stable(in_ep_o.data)))
    else $error("offered byte changed or was dropped before the host took it");

  // done and stall last one cycle
  done_is_pulse: assert property (@(posedge clk) disable iff (reset)
    !(in_ep_o.data_done && $past(in_ep_o.data_done)))
    else $error("data_done held longer than one cycle");

  stall_is_pulse: assert property (@(posedge clk) disable iff (reset)
    !(in_ep_o.stall && $past(in_ep_o.stall)))
    else $error("stall held longer than one cycle");

  req_ends_with_done: assert property (@(posedge clk) disable iff (reset)
    $fell(in_ep_o.req) |-> in_ep_o.data_done)
    else $error("req dropped without data_done");

endmodule

bind in_data_source ctrl_ep_assert u_ctrl_ep_assert (
  .clk     (clk),
  .reset   (reset),
  .in_ep   (in_ep),
  .in_ep_o (in_ep_o)
);

`default_nettype wire

// File: dv/ep_clock_gen.sv
`default_nettype none

module ep_clock_gen #(
  parameter int period = 20
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever #(period / 2) clk = ~clk;  // half period high, half low
  end

endmodule

`default_nettype wire

// File: verilog/usb_dfu_ctrl_ep.sv
`default_nettype none

module usb_dfu_ctrl_ep #(
  parameter int max_in_packet_size  = 32,
  parameter int max_out_packet_size = 32,
  parameter int fw_page_size        = 4096
) (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::out_ep_in_t out_ep,
  output logic                    out_ep_req,
  input  usb_dfu_pkg::in_ep_in_t  in_ep,
  output usb_dfu_pkg::in_ep_out_t in_ep_o,
  output logic [6:0]              dev_addr
);
  import usb_dfu_pkg::*;

  setup_pkt_u setup_pkt;
  logic       pkt_start;
  logic       pkt_end;
  xfr_state_e state;
  logic       setup_stage_end;
  logic       status_stage_end;
  logic       send_zlp;
  xfr_resp_t  resp;
  logic [7:0] dfu_state;
  logic       all_sent;

  assign out_ep_req = out_ep.data_avail;  // take every out byte offered

  //////////////////////////////
  // input side
  setup_capture u_setup_capture (
    .clk              (clk),
    .reset            (reset),
    .out_ep           (out_ep),
    .status_stage_end (status_stage_end),
    .setup_pkt        (setup_pkt),
    .pkt_start        (pkt_start),
    .pkt_end          (pkt_end)
  );

  //////////////////////////////
  // stage control and decode
  ctrl_xfr_fsm u_ctrl_xfr_fsm (
    .clk              (clk),
    .reset            (reset),
    .setup_pkt        (setup_pkt),
    .pkt_start        (pkt_start),
    .pkt_end          (pkt_end),
    .out_setup        (out_ep.setup),
    .out_acked        (out_ep.acked),
    .in_acked         (in_ep.acked),
    .in_stall         (in_ep_o.stall),
    .all_sent         (all_sent),
    .state            (state),
    .setup_stage_end  (setup_stage_end),
    .data_stage_end   (),
    .status_stage_end (status_stage_end),
    .send_zlp         (send_zlp)
  );

  request_decoder #(
    .max_in_packet_size (max_in_packet_size),
    .fw_page_size       (fw_page_size)
  ) u_request_decoder (
    .clk              (clk),
    .reset            (reset),
    .setup_pkt        (setup_pkt),
    .setup_stage_end  (setup_stage_end),
    .status_stage_end (status_stage_end),
    .resp             (resp),
    .dfu_state        (dfu_state),
    .dev_addr         (dev_addr)
  );

  //////////////////////////////
  // output side
  in_data_source #(
    .max_in_packet_size  (max_in_packet_size),
    .max_out_packet_size (max_out_packet_size)
  ) u_in_data_source (
    .clk              (clk),
    .reset            (reset),
    .resp             (resp),
    .w_length_lo      (setup_pkt.fields.w_length[7:0]),
    .state            (state),
    .setup_stage_end  (setup_stage_end),
    .status_stage_end (status_stage_end),
    .send_zlp         (send_zlp),
    .dfu_state        (dfu_state),
    .in_ep            (in_ep),
    .in_ep_o          (in_ep_o),
    .all_sent         (all_sent)
  );

endmodule

`default_nettype wire

// File: verilog/in_data_source.sv
`default_nettype none

module in_data_source #(
  parameter int max_in_packet_size  = 32,
  parameter int max_out_packet_size = 32
) (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::xfr_resp_t  resp,
  input  logic [7:0]              w_length_lo,
  input  usb_dfu_pkg::xfr_state_e state,
  input  logic                    setup_stage_end,
  input  logic                    status_stage_end,
  input  logic                    send_zlp,
  input  logic [7:0]              dfu_state,
  input  usb_dfu_pkg::in_ep_in_t  in_ep,
  output usb_dfu_pkg::in_ep_out_t in_ep_o,
  output logic                    all_sent
);
  import usb_dfu_pkg::*;

  localparam logic [7:0] out_mps = 8'(max_out_packet_size);
  localparam logic [7:0] in_mps  = 8'(max_in_packet_size);
  localparam int         rom_size = 49;

  localparam logic [7:0] ep_rom [rom_size] = '{
    // device
    8'd18, 8'd1, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, out_mps, 8'h50,
    8'h1d, 8'h30, 8'h61, 8'h00, 8'h00, 8'd0, 8'd0, 8'd0, 8'd1,
    // configuration
    8'd9, 8'd2, 8'd27, 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,
    // interface, dfu mode
    8'd9, 8'd4, 8'd0, 8'd0, 8'd0, 8'hfe, 8'd1, 8'd2, 8'd0,
    // dfu functional, detach timeout 255
    8'd9, 8'h21, 8'h0b, 8'hff, 8'd0, out_mps, 8'd0, 8'h1a, 8'h01,
    // string 0, us english
    8'd4, 8'd3, 8'h09, 8'h04
  };

  logic [11:0] addr;
  logic [7:0]  remaining;  // bytes left in the response
  logic [7:0]  limit;      // bytes left the host asked for
  logic        load_q;
  logic        all_sent_q;
  logic        stall_q;
  logic        req;
  logic        consume;
  logic [7:0]  rom_byte;
  logic [7:0]  stat_byte;
  logic [7:0]  in_byte;

  assign all_sent = (remaining == 8'd0) || (limit == 8'd0);
  assign req      = (state == xfr_data_in) && !all_sent;
  assign consume  = req && in_ep.data_free && in_ep.grant;

  always_ff @(posedge clk) begin
    if (reset) begin
      addr       <= '0;
      remaining  <= '0;
      limit      <= '0;
      load_q     <= 1'b0;
      all_sent_q <= 1'b1;
      stall_q    <= 1'b0;
    end else begin
      load_q     <= setup_stage_end;  // plan is valid one cycle later
      all_sent_q <= all_sent;
      stall_q    <= load_q && resp.stall;
      if (load_q) begin
        addr      <= resp.addr;
        remaining <= (resp.length > in_mps) ? in_mps : resp.length;  // one packet
        limit     <= w_length_lo;
      end else if (consume) begin
        addr      <= addr + 12'd1;
        remaining <= remaining - 8'd1;
        limit     <= limit - 8'd1;
      end
      if (status_stage_end) begin
        addr      <= '0;
        remaining <= '0;
        limit     <= '0;
      end
    end
  end

  ////////////////////////////////
  // byte select
  always_comb begin
    rom_byte = (addr < 12'(rom_size)) ? ep_rom[addr[5:0]] : 8'h00;
    case (addr[2:0])
      3'd0:    stat_byte = dfu_status_ok;
      3'd4:    stat_byte = dfu_state;  // bState, live
      default: stat_byte = 8'h00;      // poll timeout and istring
    endcase
    case (resp.src)
      src_dfu_status: in_byte = stat_byte;
      src_firmware:   in_byte = addr[7:0];  // test pattern
      default:        in_byte = rom_byte;
    endcase
  end

  always_comb begin
    in_ep_o.req       = req;
    in_ep_o.data_put  = req && in_ep.data_free;
    in_ep_o.data      = in_byte;
    in_ep_o.data_done = (all_sent && !all_sent_q && state == xfr_data_in) || send_zlp;
    in_ep_o.stall     = stall_q;
  end

endmodule

`default_nettype wire

// File: verilog/request_decoder.sv
`default_nettype none

module request_decoder #(
  parameter int max_in_packet_size = 32,
  parameter int fw_page_size       = 4096
) (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::setup_pkt_u setup_pkt,
  input  logic                    setup_stage_end,
  input  logic                    status_stage_end,
  output usb_dfu_pkg::xfr_resp_t  resp,
  output logic [7:0]              dfu_state,
  output logic [6:0]              dev_addr
);
  import usb_dfu_pkg::*;

  logic [1:0]  req_type;
  logic [7:0]  b_request;
  logic [15:0] w_value;
  logic [15:0] block_start;  // block number of the first upload
  logic [15:0] block_off;
  logic [31:0] upload_off;
  logic        save_addr;
  logic [6:0]  new_addr;

  assign req_type   = setup_pkt.fields.bm_request_type[6:5];
  assign b_request  = setup_pkt.fields.b_request;
  assign w_value    = setup_pkt.fields.w_value;
  assign block_off  = w_value - block_start;
  assign upload_off = (32'(block_off) * max_in_packet_size) % fw_page_size;  // wraps in page

  always_ff @(posedge clk) begin
    if (reset) begin
      resp        <= '0;
      dfu_state   <= dfu_idle;
      block_start <= '0;
      save_addr   <= 1'b0;
      dev_addr    <= '0;
    end else begin
      if (setup_stage_end) begin
        resp <= '{src: src_ep_rom, addr: '0, length: '0, stall: 1'b0};
        if (req_type == req_type_std) begin
          case (b_request)
            req_get_descriptor: begin
              case (w_value[15:8])
                desc_device: begin
                  resp.addr   <= ep_rom_dev_off;
                  resp.length <= 8'd18;
                end
                desc_config: begin
                  resp.addr   <= ep_rom_cfg_off;
                  resp.length <= 8'd27;  // wTotalLength
                end
                desc_string: begin
                  if (w_value[7:0] == 8'd0) begin
                    resp.addr   <= ep_rom_lang_off;
                    resp.length <= 8'd4;
                  end
                end
                desc_qualifier: resp.stall <= 1'b1;  // full-speed only device
                default: ;
              endcase
            end
            req_set_address: begin
              save_addr <= 1'b1;  // old address still owns the status stage
              new_addr  <= w_value[6:0];
            end
            req_set_configuration: ;  // single config, nothing to hold
            default: ;
          endcase
        end else if (req_type == req_type_class) begin
          case (b_request)
            dfu_upload: begin
              resp.src    <= src_firmware;
              resp.length <= 8'(max_in_packet_size);
              if (dfu_state == dfu_upload_idle) begin
                resp.addr <= upload_off[11:0];
              end else begin
                block_start <= w_value;  // first block reads from 0
                dfu_state   <= dfu_upload_idle;
              end
            end
            dfu_getstatus: begin
              resp.src    <= src_dfu_status;
              resp.length <= 8'd6;
            end
            dfu_getstate: begin
              resp.src    <= src_dfu_status;
              resp.addr   <= 12'h004;  // bState
              resp.length <= 8'd1;
            end
            dfu_abort: dfu_state <= dfu_idle;
            default: ;
          endcase
        end
      end

      if (status_stage_end && save_addr) begin
        dev_addr  <= new_addr;
        save_addr <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/ctrl_xfr_fsm.sv
`default_nettype none

module ctrl_xfr_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::setup_pkt_u setup_pkt,
  input  logic                    pkt_start,
  input  logic                    pkt_end,
  input  logic                    out_setup,
  input  logic                    out_acked,
  input  logic                    in_acked,
  input  logic                    in_stall,
  input  logic                    all_sent,
  output usb_dfu_pkg::xfr_state_e state,
  output logic                    setup_stage_end,
  output logic                    data_stage_end,
  output logic                    status_stage_end,
  output logic                    send_zlp
);
  import usb_dfu_pkg::*;

  xfr_state_e next_state;
  logic       has_data;
  logic       dir_in;

  assign has_data = |setup_pkt.fields.w_length;
  assign dir_in   = setup_pkt.fields.bm_request_type[7];  // device to host

  always_comb begin
    next_state       = state;
    setup_stage_end  = 1'b0;
    data_stage_end   = 1'b0;
    status_stage_end = 1'b0;
    send_zlp         = 1'b0;
    case (state)
      xfr_idle: begin
        if (pkt_start && out_setup) begin
          next_state = xfr_setup;
        end
      end
      xfr_setup: begin
        if (pkt_end) begin
          setup_stage_end = 1'b1;
          if (has_data && dir_in) begin
            next_state = xfr_data_in;
          end else if (has_data) begin
            next_state = xfr_data_out;
          end else begin
            next_state = xfr_status_in;
            send_zlp   = 1'b1;  // no-data request, status is a zlp
          end
        end
      end
      xfr_data_in: begin
        if (in_acked && all_sent) begin
          next_state     = xfr_status_out;
          data_stage_end = 1'b1;
        end
      end
      xfr_data_out: begin
        if (out_acked) begin
          next_state     = xfr_status_in;
          data_stage_end = 1'b1;
          send_zlp       = 1'b1;
        end
      end
      xfr_status_in: begin
        if (in_acked) begin
          next_state       = xfr_idle;
          status_stage_end = 1'b1;
        end
      end
      xfr_status_out: begin
        if (out_acked) begin
          next_state       = xfr_idle;
          status_stage_end = 1'b1;
        end
      end
      default: next_state = xfr_idle;
    endcase

    // a stall aborts whatever stage follows setup
    if (in_stall && state != xfr_idle && state != xfr_setup) begin
      next_state       = xfr_idle;
      data_stage_end   = (state == xfr_data_in) || (state == xfr_data_out);
      status_stage_end = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= xfr_idle;
    end else begin
      state <= next_state;
    end
  end

endmodule

`default_nettype wire

// File: verilog/setup_capture.sv
`default_nettype none

module setup_capture (
  input  logic                    clk,
  input  logic                    reset,
  input  usb_dfu_pkg::out_ep_in_t out_ep,
  input  logic                    status_stage_end,
  output usb_dfu_pkg::setup_pkt_u setup_pkt,
  output logic                    pkt_start,
  output logic                    pkt_end
);

  logic       setup_valid;  // setup byte on out_ep.data this cycle
  logic       avail_q;
  logic [2:0] byte_idx;

  always_ff @(posedge clk) begin
    if (reset) begin
      setup_valid <= 1'b0;
      avail_q     <= 1'b0;
      pkt_start   <= 1'b0;
      pkt_end     <= 1'b0;
      byte_idx    <= '0;
    end else begin
      setup_valid <= out_ep.data_avail && out_ep.grant && out_ep.setup;
      avail_q     <= out_ep.data_avail;
      pkt_start   <= out_ep.data_avail && !avail_q;  // rising edge
      pkt_end     <= !out_ep.data_avail && avail_q;  // falling edge
      if (status_stage_end) begin
        byte_idx <= '0;
      end else if (setup_valid) begin
        byte_idx <= byte_idx + 3'd1;
      end
    end
  end

  // byte view of the packet
  always_ff @(posedge clk) begin
    if (setup_valid) begin
      setup_pkt.bytes[byte_idx] <= out_ep.data;
    end
  end

endmodule

`default_nettype wire

// File: verilog/usb_dfu_pkg.sv
`default_nettype none

package usb_dfu_pkg;

  //////////////////////////////
  // control transfer stages
  typedef enum logic [2:0] {
    xfr_idle, xfr_setup, xfr_data_in, xfr_data_out, xfr_status_in, xfr_status_out
  } xfr_state_e;

  // setup packet fields, little-endian words
  typedef struct packed {
    logic [15:0] w_length;
    logic [15:0] w_index;
    logic [15:0] w_value;
    logic [7:0]  b_request;
    logic [7:0]  bm_request_type;
  } setup_fields_t;

  typedef union packed {
    logic [7:0][7:0] bytes;  // byte 0 is bm_request_type
    setup_fields_t   fields;
  } setup_pkt_u;

  typedef enum logic [1:0] {src_ep_rom, src_dfu_status, src_firmware} data_src_e;

  typedef struct packed {
    data_src_e   src;
    logic [11:0] addr;
    logic [7:0]  length;
    logic        stall;
  } xfr_resp_t;

  //////////////////////////////
  // endpoint handshakes
  typedef struct packed {
    logic       grant;
    logic       data_avail;
    logic       setup;
    logic [7:0] data;
    logic       acked;
  } out_ep_in_t;

  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_in_t;

  typedef struct packed {
    logic       req;
    logic       data_put;
    logic [7:0] data;
    logic       data_done;
    logic       stall;
  } in_ep_out_t;

  //////////////////////////////
  // request and descriptor codes
  localparam logic [1:0] req_type_std   = 2'd0;
  localparam logic [1:0] req_type_class = 2'd1;

  localparam logic [7:0] req_get_descriptor    = 8'd6;
  localparam logic [7:0] req_set_address       = 8'd5;
  localparam logic [7:0] req_set_configuration = 8'd9;
  localparam logic [7:0] dfu_upload            = 8'd2;
  localparam logic [7:0] dfu_getstatus         = 8'd3;
  localparam logic [7:0] dfu_getstate          = 8'd5;
  localparam logic [7:0] dfu_abort             = 8'd6;

  localparam logic [7:0] desc_device    = 8'd1;
  localparam logic [7:0] desc_config    = 8'd2;
  localparam logic [7:0] desc_string    = 8'd3;
  localparam logic [7:0] desc_qualifier = 8'd6;

  localparam logic [11:0] ep_rom_dev_off  = 12'h000;
  localparam logic [11:0] ep_rom_cfg_off  = 12'h012;
  localparam logic [11:0] ep_rom_lang_off = 12'h02d;

  localparam logic [7:0] dfu_idle        = 8'h02;
  localparam logic [7:0] dfu_upload_idle = 8'h09;
  localparam logic [7:0] dfu_status_ok   = 8'h00;

endpackage

`default_nettype wire
